// File: Bender.yml
package:
  name: gen

sources:
  - verilog/gen_pkg.sv
  - verilog/gen_regs.sv
  - verilog/gen_table_reader.sv
  - verilog/gen_credit_fifo.sv
  - verilog/gen_lin_out.sv
  - verilog/gen_top.sv
  - target: simulation
    files:
      - tb/gen_tb.sv

// File: build.f
verilog/gen_pkg.sv
verilog/gen_regs.sv
verilog/gen_table_reader.sv
verilog/gen_credit_fifo.sv
verilog/gen_lin_out.sv
verilog/gen_top.sv
tb/gen_tb.sv

// File: tb/gen_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the waveform generator top level
// bus tasks program the table and registers while a reference model
// predicts every accepted DAC sample and assertions flag any mismatch
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module gen_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int AW         = 10;
  localparam int DEPTH      = 4;
  localparam int TMO        = 2000;
  localparam int RDY_FREE   = 0;
  localparam int RDY_RANDOM = 1;
  localparam int RDY_HOLD   = 2;

  logic              bus;
  logic              ctl_rst;
  gen_pkg::bus_req_t bus_req;
  gen_pkg::bus_rsp_t bus_rsp;
  gen_pkg::sample_t  dac;
  logic              dac_valid;
  logic              dac_ready;
  logic              irq;

  // reference state
  gen_pkg::sample_t  tbl_ref [64];
  gen_pkg::sample_t  exp_q [$];
  logic [31:0]       c_siz;
  logic [31:0]       c_off;
  logic [31:0]       c_ste;
  logic              c_mode;
  logic signed [15:0] c_mul;
  gen_pkg::sample_t  c_sum;
  logic              c_ena;
  logic [31:0]       tbl_lfsr = 32'hbda3_5212;
  logic [31:0]       rdy_lfsr = 32'hbda3_5212;
  int                rdy_mode = RDY_FREE;
  int                err_cnt  = 0;
  int                reg_cnt  = 0;
  int                acc_cnt  = 0;

  gen_top #(
    .AW    (AW),
    .DEPTH (DEPTH)
  ) i_gen_top (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .dac       (dac),
    .dac_valid (dac_valid),
    .dac_ready (dac_ready),
    .irq       (irq)
  );

  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random source and helpers
  ////////////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      tbl_lfsr = lfsr_step(tbl_lfsr);
      v = {v[30:0], tbl_lfsr[0]};
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("test failed");
    $finish;
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    reg_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("[FAIL] %0t %s expected 0x%08h got 0x%08h", $time, name, exp, got);
    end
  endtask

  // dac_ready is free running, random or held low
  initial begin
    dac_ready = 1'b1;
    forever begin
      @(negedge bus);
      if (rdy_mode == RDY_RANDOM) begin
        rdy_lfsr  = lfsr_step(rdy_lfsr);
        dac_ready = rdy_lfsr[0];
      end else begin
        dac_ready = (rdy_mode == RDY_FREE);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks are called and return on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_access(input logic wr, input logic [8:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int t;
    t = 0;
    bus_req = '{wen: wr, ren: !wr, addr: addr, wdata: wdata};
    @(negedge bus);
    bus_req = '0;
    while (!bus_rsp.ack && t < TMO) begin
      t++;
      @(negedge bus);
    end
    if (!bus_rsp.ack) begin
      abort_on_timeout("bus ack");
    end
    rdata = bus_rsp.rdata;
    // gap cycle so control pulses settle before the next access
    @(negedge bus);
  endtask

  task automatic reg_write(input gen_pkg::gen_reg_e r, input logic [31:0] d);
    logic [31:0] dummy;
    bus_access(1'b1, {1'b0, r}, d, dummy);
  endtask

  task automatic check_reg(input gen_pkg::gen_reg_e r, input logic [31:0] exp,
                           input string name);
    logic [31:0] v;
    bus_access(1'b0, {1'b0, r}, '0, v);
    compare_value(name, v, exp);
  endtask

  task automatic apply_config(input logic [31:0] siz, input logic [31:0] off,
                              input logic [31:0] ste, input logic mode,
                              input logic signed [15:0] mul,
                              input gen_pkg::sample_t sum, input logic ena);
    c_siz  = siz;
    c_off  = off;
    c_ste  = ste;
    c_mode = mode;
    c_mul  = mul;
    c_sum  = sum;
    c_ena  = ena;
    reg_write(gen_pkg::REG_SIZ, siz);
    reg_write(gen_pkg::REG_OFF, off);
    reg_write(gen_pkg::REG_STE, ste);
    reg_write(gen_pkg::REG_MODE, {31'd0, mode});
    reg_write(gen_pkg::REG_MUL, 32'(mul));
    reg_write(gen_pkg::REG_SUM, 32'(sum));
    reg_write(gen_pkg::REG_ENA, {31'd0, ena});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // gain with a floor shift followed by offset, saturation and enable
  function automatic gen_pkg::sample_t lin_model(input gen_pkg::sample_t x);
    int p;
    int s;
    p = int'(x) * int'(c_mul);
    p = p >>> 14;
    s = p + int'(c_sum);
    if (s > 8191) begin
      s = 8191;
    end else if (s < -8192) begin
      s = -8192;
    end
    if (!c_ena) begin
      s = 0;
    end
    return 14'(s);
  endfunction

  // walk the phase through the table and wrap or end the pass
  task automatic build_expected(input int n_max);
    logic [31:0] ph;
    logic [31:0] ph_add;
    logic        done;
    int          k;
    exp_q.delete();
    ph   = c_off;
    done = 1'b0;
    k    = 0;
    while (!done && k < n_max) begin
      exp_q.push_back(lin_model(tbl_ref[ph[21:16]]));
      ph_add = ph + c_ste;
      if (ph_add >= c_siz) begin
        if (c_mode) begin
          done = 1'b1;
        end else begin
          ph = ph_add - c_siz;
        end
      end else begin
        ph = ph_add;
      end
      k++;
    end
  endtask

  // every DAC transfer is counted and checked against the head of the queue
  always @(posedge bus) begin
    if (!ctl_rst && dac_valid && dac_ready) begin
      acc_cnt++;
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("DAC delivered a sample at %0t when none was expected", $time);
      end else begin
        assert (dac == exp_q[0]) else begin
          err_cnt++;
          $display("[FAIL] %0t dac expected %0d got %0d", $time, exp_q[0], dac);
        end
        void'(exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // protocol assertions
  ////////////////////////////////////////////////////////////////////////////

  ack_one_cycle: assert property (@(posedge bus) disable iff (ctl_rst)
    (bus_req.wen | bus_req.ren) |=> bus_rsp.ack)
    else begin
      err_cnt++;
      $display("bus ack did not follow a request by one cycle at %0t", $time);
    end

  dac_stall_hold: assert property (@(posedge bus) disable iff (ctl_rst)
    (dac_valid && !dac_ready) |=> (dac_valid && $stable(dac)))
    else begin
      err_cnt++;
      $display("DAC output changed while stalled at %0t", $time);
    end

  fifo_no_overflow: assert property (@(posedge bus) disable iff (ctl_rst)
    i_gen_top.push |-> (i_gen_top.i_fifo.fill < DEPTH))
    else begin
      err_cnt++;
      $display("sample FIFO overflowed at %0t", $time);
    end

  fifo_no_underflow: assert property (@(posedge bus) disable iff (ctl_rst)
    i_gen_top.pop |-> i_gen_top.not_empty)
    else begin
      err_cnt++;
      $display("sample FIFO underflowed at %0t", $time);
    end

  credit_bounds: assert property (@(posedge bus) disable iff (ctl_rst)
    i_gen_top.i_reader.credit <= DEPTH)
    else begin
      err_cnt++;
      $display("producer credit went above the FIFO depth at %0t", $time);
    end

  ////////////////////////////////////////////////////////////////////////////
  // wait loops
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_samples(input int base, input int n, input string what);
    int t;
    t = 0;
    while (acc_cnt - base < n && t < TMO) begin
      t++;
      @(negedge bus);
    end
    if (acc_cnt - base < n) begin
      abort_on_timeout(what);
    end
  endtask

  // output counts as stopped after 16 quiet cycles
  task automatic wait_drain();
    int t;
    int quiet;
    t     = 0;
    quiet = 0;
    while (quiet < 16 && t < TMO) begin
      quiet = dac_valid ? 0 : quiet + 1;
      t++;
      @(negedge bus);
    end
    if (quiet < 16) begin
      abort_on_timeout("DAC output to go quiet");
    end
  endtask

  task automatic wait_irq(input logic level);
    int t;
    t = 0;
    while (irq !== level && t < TMO) begin
      t++;
      @(negedge bus);
    end
    if (irq !== level) begin
      abort_on_timeout(level ? "irq to rise" : "irq to fall");
    end
  endtask

  // start, trigger, take n samples, stop and drain
  task automatic run_continuous(input int n, input string what);
    int base;
    build_expected(n + 40);
    base = acc_cnt;
    reg_write(gen_pkg::REG_CTL, 32'h1);
    check_reg(gen_pkg::REG_CTL, 32'h2, "ctl armed");
    reg_write(gen_pkg::REG_CTL, 32'h4);
    check_reg(gen_pkg::REG_CTL, 32'h4, "ctl running");
    wait_samples(base, n, what);
    reg_write(gen_pkg::REG_CTL, 32'h2);
    wait_drain();
    check_reg(gen_pkg::REG_CTL, 32'h0, "ctl idle after stop");
    // interrupts are disabled here, so the trigger must not set status
    check_reg(gen_pkg::REG_IRQ_STS, 32'h0, "irq status while disabled");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] v;
    int          base;
    bus_req = '0;
    ctl_rst = 1'b1;

    // outputs stay quiet throughout reset
    for (int i = 0; i < 16; i++) begin
      @(negedge bus);
      if (i > 0) begin
        compare_value("dac_valid", {31'd0, dac_valid}, 32'd0);
        compare_value("irq", {31'd0, irq}, 32'd0);
        compare_value("bus_rsp.ack", {31'd0, bus_rsp.ack}, 32'd0);
      end
    end
    ctl_rst = 1'b0;
    @(negedge bus);
    compare_value("dac_valid", {31'd0, dac_valid}, 32'd0);
    compare_value("irq", {31'd0, irq}, 32'd0);

    check_reg(gen_pkg::REG_CTL, 32'h0, "ctl");
    check_reg(gen_pkg::REG_IRQ_ENA, 32'h0, "irq enable");
    check_reg(gen_pkg::REG_IRQ_STS, 32'h0, "irq status");
    check_reg(gen_pkg::REG_SIZ, 32'h0, "size");
    check_reg(gen_pkg::REG_OFF, 32'h0, "offset");
    check_reg(gen_pkg::REG_STE, 32'h0, "step");
    check_reg(gen_pkg::REG_MODE, 32'h0, "mode");
    check_reg(gen_pkg::REG_MUL, 32'h0, "gain");
    check_reg(gen_pkg::REG_SUM, 32'h0, "sum");
    check_reg(gen_pkg::REG_ENA, 32'h0, "enable");

    // register write and readback
    apply_config(32'h0012_3456, 32'h0000_8000, 32'h0001_2000, 1'b1,
                 16'sh1234, 14'sh0abc, 1'b1);
    reg_write(gen_pkg::REG_IRQ_ENA, 32'h3);
    check_reg(gen_pkg::REG_SIZ, 32'h0012_3456, "size");
    check_reg(gen_pkg::REG_OFF, 32'h0000_8000, "offset");
    check_reg(gen_pkg::REG_STE, 32'h0001_2000, "step");
    check_reg(gen_pkg::REG_MODE, 32'h1, "mode");
    check_reg(gen_pkg::REG_MUL, 32'h0000_1234, "gain");
    check_reg(gen_pkg::REG_SUM, 32'h0000_0abc, "sum");
    check_reg(gen_pkg::REG_ENA, 32'h1, "enable");
    check_reg(gen_pkg::REG_IRQ_ENA, 32'h3, "irq enable");
    reg_write(gen_pkg::REG_IRQ_ENA, 32'h0);

    // random table of 64 entries with 14 bits each
    for (int i = 0; i < 64; i++) begin
      take_bits(14, v);
      tbl_ref[i] = v[13:0];
      bus_access(1'b1, 9'h100 | 9'(i * 4), v, v);
    end
    bus_access(1'b0, 9'h104, '0, v);
    compare_value("table readback", v, 32'h0);

    // continuous playback at unity gain
    apply_config(32'd16 << 16, 32'h0, 32'h0001_0000, 1'b0, 16'sd16384, '0, 1'b1);
    run_continuous(40, "samples at step 1.0");
    apply_config(32'd16 << 16, 32'h0, 32'h0000_8000, 1'b0, 16'sd16384, '0, 1'b1);
    run_continuous(40, "samples at step 0.5");
    apply_config(32'd16 << 16, 32'd5 << 16, 32'h0001_0000, 1'b0, 16'sd16384, '0, 1'b1);
    run_continuous(30, "samples with offset");

    // back-pressure from random dac_ready
    rdy_mode = RDY_RANDOM;
    apply_config(32'd20 << 16, 32'd3 << 16, 32'h0000_c000, 1'b0, 16'sd16384, '0, 1'b1);
    run_continuous(80, "samples under back-pressure");
    rdy_mode = RDY_FREE;

    // single pass with the DAC stalled so the trigger interrupt comes first
    reg_write(gen_pkg::REG_IRQ_ENA, 32'h3);
    apply_config(32'd24 << 16, 32'h0, 32'h0002_0000, 1'b1, 16'sd16384, '0, 1'b1);
    build_expected(100);
    base     = acc_cnt;
    rdy_mode = RDY_HOLD;
    reg_write(gen_pkg::REG_CTL, 32'h1);
    reg_write(gen_pkg::REG_CTL, 32'h4);
    check_reg(gen_pkg::REG_CTL, 32'h4, "ctl running");
    wait_irq(1'b1);
    check_reg(gen_pkg::REG_IRQ_STS, 32'h1, "irq status after trigger");
    reg_write(gen_pkg::REG_IRQ_STS, 32'h1);
    wait_irq(1'b0);
    check_reg(gen_pkg::REG_IRQ_STS, 32'h0, "irq status after clear");
    rdy_mode = RDY_FREE;
    wait_irq(1'b1);
    wait_samples(base, int'(c_siz / c_ste), "single pass samples");
    wait_drain();
    compare_value("single pass count", 32'(acc_cnt - base), c_siz / c_ste);
    check_reg(gen_pkg::REG_IRQ_STS, 32'h2, "irq status after last sample");
    check_reg(gen_pkg::REG_CTL, 32'h0, "ctl idle after pass");
    reg_write(gen_pkg::REG_IRQ_STS, 32'h3);
    wait_irq(1'b0);
    reg_write(gen_pkg::REG_IRQ_ENA, 32'h0);

    // linear stage saturates both ways and then runs with the output disabled
    apply_config(32'd16 << 16, 32'h0, 32'h0001_0000, 1'b0, 16'sh7fff, 14'sd2000, 1'b1);
    run_continuous(32, "samples with positive offset");
    apply_config(32'd16 << 16, 32'h0, 32'h0001_0000, 1'b0, 16'sh7fff, -14'sd3000, 1'b1);
    run_continuous(32, "samples with negative offset");
    apply_config(32'd16 << 16, 32'h0, 32'h0001_0000, 1'b0, 16'sd16384, '0, 1'b0);
    run_continuous(20, "samples with output disabled");

    $display("errors %0d, register checks %0d, samples accepted %0d",
             err_cnt, reg_cnt, acc_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/gen_credit_fifo.sv
////////////////////////////////////////////////////////////////////////////
// sample buffer between producer and output stage
// circular buffer, each pop returns one credit a cycle later
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module gen_credit_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic              bus,
  input  logic              ctl_rst,
  input  logic              push,
  input  gen_pkg::gen_smp_t smp_in,
  input  logic              pop,
  output gen_pkg::gen_smp_t smp_out,
  output logic              not_empty,
  output logic              credit_ret
);

  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  gen_pkg::gen_smp_t mem [DEPTH];
  logic [PW-1:0]     wptr;
  logic [PW-1:0]     rptr;
  logic [CW-1:0]     fill;

  // storage
  always_ff @(posedge bus) begin
    if (push) begin
      mem[wptr] <= smp_in;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      wptr       <= '0;
      rptr       <= '0;
      fill       <= '0;
      credit_ret <= 1'b0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      fill       <= fill + CW'(push) - CW'(pop);
      credit_ret <= pop;
    end
  end

  // head entry
  assign smp_out   = mem[rptr];
  assign not_empty = (fill != '0);

  // producer credit keeps the buffer from overflowing
  no_overflow: assert property (@(posedge bus) disable iff (ctl_rst)
    push |-> (fill < CW'(DEPTH)));

  // output stage only pops what is there
  no_underflow: assert property (@(posedge bus) disable iff (ctl_rst)
    pop |-> not_empty);

endmodule

`default_nettype wire

// File: verilog/gen_lin_out.sv
////////////////////////////////////////////////////////////////////////////
// linear output stage
// stage one applies gain, stage two offset, saturation and enable
// drives the DAC over valid/ready, stalls under back-pressure
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module gen_lin_out (
  input  logic              bus,
  input  logic              ctl_rst,
  input  gen_pkg::gen_cfg_t cfg,
  input  logic              not_empty,
  input  gen_pkg::gen_smp_t smp,
  output logic              pop,
  output gen_pkg::sample_t  dac,
  output logic              dac_valid,
  input  logic              dac_ready
);

  logic               en1;
  logic               en2;
  logic               s1_vld;
  logic signed [15:0] s1_dat;
  logic signed [29:0] prod;
  logic signed [16:0] sum;
  gen_pkg::sample_t   sat;

  // stage advance, stage two frees up on a DAC transfer
  assign en2 = ~dac_valid | dac_ready;
  assign en1 = ~s1_vld | en2;
  assign pop = not_empty & en1;

  ////////////////////////////////////////////////////////////////////////////
  // stage one, gain
  ////////////////////////////////////////////////////////////////////////////

  assign prod = $signed(smp.dat) * $signed(cfg.mul);

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      s1_vld <= 1'b0;
    end else if (en1) begin
      s1_vld <= not_empty;
    end
  end

  // dropping the low bits floors toward minus infinity
  always_ff @(posedge bus) begin
    if (pop) begin
      s1_dat <= prod[gen_pkg::GEN_MUL_FRAC +: 16];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage two, offset, saturate, enable
  ////////////////////////////////////////////////////////////////////////////

  assign sum = {s1_dat[15], s1_dat} + {{3{cfg.sum[13]}}, cfg.sum};

  always_comb begin
    if (sum > 17'sd8191) begin
      sat = 14'sd8191;
    end else if (sum < -17'sd8192) begin
      sat = -14'sd8192;
    end else begin
      sat = sum[13:0];
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      dac_valid <= 1'b0;
    end else if (en2) begin
      dac_valid <= s1_vld;
    end
  end

  always_ff @(posedge bus) begin
    if (en2 && s1_vld) begin
      dac <= cfg.ena ? sat : '0;
    end
  end

  // a stalled sample stays put until the DAC takes it
  dac_hold: assert property (@(posedge bus) disable iff (ctl_rst)
    (dac_valid && !dac_ready) |=> (dac_valid && $stable(dac)));

endmodule

`default_nettype wire

// File: verilog/gen_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types for the waveform generator
// bus request/response, config and control structs, producer states,
// register offsets and fixed point constants
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package gen_pkg;

  // fixed point fraction widths
  localparam int unsigned GEN_CWF      = 16;
  localparam int unsigned GEN_MUL_FRAC = 14;

  // signed DAC sample
  typedef logic signed [13:0] sample_t;

  // one sample in flight, lst marks the end of a single pass
  typedef struct packed {
    sample_t dat;
    logic    lst;
  } gen_smp_t;

  // system bus, address bit 8 selects the table
  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [8:0]  addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  // configuration
  typedef struct packed {
    logic [31:0]        siz;   // table size, 16.16
    logic [31:0]        off;   // start phase, 16.16
    logic [31:0]        ste;   // phase step, 16.16
    logic               mode;  // 1 = single pass
    logic signed [15:0] mul;   // gain, 1.0 = 16384
    sample_t            sum;   // offset
    logic               ena;   // output enable
  } gen_cfg_t;

  // one cycle control pulses
  typedef struct packed {
    logic str;
    logic stp;
    logic trg;
  } gen_ctl_t;

  // producer status
  typedef struct packed {
    logic arm;
    logic run;
    logic lst;  // last sample pushed
  } gen_sts_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_RUN
  } gen_state_e;

  typedef enum logic [7:0] {
    REG_CTL     = 8'h00,
    REG_IRQ_ENA = 8'h08,
    REG_IRQ_STS = 8'h0c,
    REG_SIZ     = 8'h20,
    REG_OFF     = 8'h24,
    REG_STE     = 8'h28,
    REG_MODE    = 8'h30,
    REG_MUL     = 8'h50,
    REG_SUM     = 8'h54,
    REG_ENA     = 8'h58
  } gen_reg_e;

endpackage

`default_nettype wire

// File: verilog/gen_regs.sv
////////////////////////////////////////////////////////////////////////////
// register file of the generator
// decodes bus writes into config and control pulses, keeps interrupt
// enable/status, reads back config and producer status
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module gen_regs (
  input  logic              bus,
  input  logic              ctl_rst,
  input  gen_pkg::bus_req_t bus_req,
  output gen_pkg::bus_rsp_t bus_rsp,
  output gen_pkg::gen_cfg_t cfg,
  output gen_pkg::gen_ctl_t ctl,
  input  gen_pkg::gen_sts_t sts,
  output logic              tbl_we,
  output logic              irq
);

  logic              reg_wen;
  logic              ctl_wen;
  gen_pkg::gen_reg_e reg_adr;
  logic              ack;
  logic [31:0]       rdata;
  logic [1:0]        irq_ena;
  logic [1:0]        irq_sts;
  logic [1:0]        irq_set;

  // register range vs table range
  assign reg_wen = bus_req.wen & ~bus_req.addr[8];
  assign reg_adr = gen_pkg::gen_reg_e'(bus_req.addr[7:0]);
  assign ctl_wen = reg_wen & (reg_adr == gen_pkg::REG_CTL);
  // table data and address are taken from bus_req by the producer
  assign tbl_we  = bus_req.wen & bus_req.addr[8];

  ////////////////////////////////////////////////////////////////////////////
  // bus response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      ack <= 1'b0;
    end else begin
      ack <= bus_req.wen | bus_req.ren;
    end
  end

  // read mux, table reads give zero
  always_ff @(posedge bus) begin
    if (bus_req.ren) begin
      if (bus_req.addr[8]) begin
        rdata <= '0;
      end else begin
        case (reg_adr)
          gen_pkg::REG_CTL:     rdata <= {29'd0, sts.run, sts.arm, 1'b0};
          gen_pkg::REG_IRQ_ENA: rdata <= {30'd0, irq_ena};
          gen_pkg::REG_IRQ_STS: rdata <= {30'd0, irq_sts};
          gen_pkg::REG_SIZ:     rdata <= cfg.siz;
          gen_pkg::REG_OFF:     rdata <= cfg.off;
          gen_pkg::REG_STE:     rdata <= cfg.ste;
          gen_pkg::REG_MODE:    rdata <= {31'd0, cfg.mode};
          gen_pkg::REG_MUL:     rdata <= {{16{cfg.mul[15]}}, cfg.mul};
          gen_pkg::REG_SUM:     rdata <= {{18{cfg.sum[13]}}, cfg.sum};
          gen_pkg::REG_ENA:     rdata <= {31'd0, cfg.ena};
          default:              rdata <= '0;
        endcase
      end
    end
  end

  assign bus_rsp = '{ack: ack, rdata: rdata};

  ////////////////////////////////////////////////////////////////////////////
  // configuration and control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      cfg     <= '0;
      irq_ena <= '0;
    end else if (reg_wen) begin
      case (reg_adr)
        gen_pkg::REG_IRQ_ENA: irq_ena  <= bus_req.wdata[1:0];
        gen_pkg::REG_SIZ:     cfg.siz  <= bus_req.wdata;
        gen_pkg::REG_OFF:     cfg.off  <= bus_req.wdata;
        gen_pkg::REG_STE:     cfg.ste  <= bus_req.wdata;
        gen_pkg::REG_MODE:    cfg.mode <= bus_req.wdata[0];
        gen_pkg::REG_MUL:     cfg.mul  <= bus_req.wdata[15:0];
        gen_pkg::REG_SUM:     cfg.sum  <= bus_req.wdata[13:0];
        gen_pkg::REG_ENA:     cfg.ena  <= bus_req.wdata[0];
        default: ;
      endcase
    end
  end

  // start/stop/trigger, high for one cycle
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      ctl <= '0;
    end else begin
      ctl.str <= ctl_wen & bus_req.wdata[0];
      ctl.stp <= ctl_wen & bus_req.wdata[1];
      ctl.trg <= ctl_wen & bus_req.wdata[2];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // interrupts
  ////////////////////////////////////////////////////////////////////////////

  // bit 0: trigger taken while armed, bit 1: last sample of a pass
  assign irq_set = {sts.lst, ctl.trg & ~ctl.stp & sts.arm} & irq_ena;

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq_sts <= '0;
      irq     <= 1'b0;
    end else begin
      if (reg_wen && (reg_adr == gen_pkg::REG_IRQ_STS)) begin
        // write one to clear, a new event still lands
        irq_sts <= (irq_sts & ~bus_req.wdata[1:0]) | irq_set;
      end else begin
        irq_sts <= irq_sts | irq_set;
      end
      irq <= |irq_sts;
    end
  end

  // ack only ever answers the request of the cycle before
  ack_after_req: assert property (@(posedge bus) disable iff (ctl_rst)
    bus_rsp.ack |-> $past(bus_req.wen | bus_req.ren));

endmodule

`default_nettype wire

// File: verilog/gen_table_reader.sv
////////////////////////////////////////////////////////////////////////////
// waveform producer
// holds the table, steps a 16.16 phase through it and pushes samples
// into the buffer while it has credit
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module gen_table_reader #(
  parameter int unsigned AW    = 10,
  parameter int unsigned DEPTH = 4
) (
  input  logic              bus,
  input  logic              ctl_rst,
  input  gen_pkg::gen_cfg_t cfg,
  input  gen_pkg::gen_ctl_t ctl,
  input  logic              tbl_we,
  input  gen_pkg::bus_req_t bus_req,
  output gen_pkg::gen_sts_t sts,
  output logic              push,
  output gen_pkg::gen_smp_t smp,
  input  logic              credit_ret
);

  localparam int unsigned CW = $clog2(DEPTH + 1);

  gen_pkg::sample_t    tbl [2**AW];
  gen_pkg::gen_state_e state;
  logic [31:0]         phase;
  logic [31:0]         phase_add;
  logic                ends;
  logic [AW-1:0]       wr_idx;
  logic [AW-1:0]       rd_idx;
  logic [CW-1:0]       credit;

  ////////////////////////////////////////////////////////////////////////////
  // table
  ////////////////////////////////////////////////////////////////////////////

  // word address, the 9-bit bus reaches the first 64 entries
  assign wr_idx = AW'(bus_req.addr[7:2]);

  always_ff @(posedge bus) begin
    if (tbl_we) begin
      tbl[wr_idx] <= bus_req.wdata[13:0];
    end
  end

  // integer part of the phase
  assign rd_idx = phase[gen_pkg::GEN_CWF +: AW];

  ////////////////////////////////////////////////////////////////////////////
  // phase and sequencing
  ////////////////////////////////////////////////////////////////////////////

  assign phase_add = phase + cfg.ste;
  // next phase runs past the table end
  assign ends      = (phase_add >= cfg.siz);

  assign push = (state == gen_pkg::ST_RUN) && (credit != '0);
  assign smp  = '{dat: tbl[rd_idx], lst: cfg.mode & ends};

  assign sts  = '{arm: (state == gen_pkg::ST_ARMED),
                  run: (state == gen_pkg::ST_RUN),
                  lst: push & cfg.mode & ends};

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      state <= gen_pkg::ST_IDLE;
      phase <= '0;
    end else if (ctl.stp) begin
      // stop wins over everything
      state <= gen_pkg::ST_IDLE;
    end else begin
      case (state)
        gen_pkg::ST_IDLE: begin
          if (ctl.str) begin
            state <= gen_pkg::ST_ARMED;
          end
        end
        gen_pkg::ST_ARMED: begin
          if (ctl.trg) begin
            state <= gen_pkg::ST_RUN;
            phase <= cfg.off;
          end
        end
        gen_pkg::ST_RUN: begin
          // phase only moves with a push, so it holds while out of credit
          if (push) begin
            if (!ends) begin
              phase <= phase_add;
            end else if (cfg.mode) begin
              state <= gen_pkg::ST_IDLE;
            end else begin
              phase <= phase_add - cfg.siz;
            end
          end
        end
        default: state <= gen_pkg::ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // credits, one per free buffer slot
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      credit <= CW'(DEPTH);
    end else begin
      credit <= credit - CW'(push) + CW'(credit_ret);
    end
  end

  // buffer returns no more credits than were spent
  credit_bound: assert property (@(posedge bus) disable iff (ctl_rst)
    credit <= CW'(DEPTH));

endmodule

`default_nettype wire

// File: verilog/gen_top.sv
////////////////////////////////////////////////////////////////////////////
// waveform generator top level
// registers, table producer, credit buffer and linear output stage
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module gen_top #(
  parameter int unsigned AW    = 10,
  parameter int unsigned DEPTH = 4
) (
  input  logic              bus,
  input  logic              ctl_rst,
  input  gen_pkg::bus_req_t bus_req,
  output gen_pkg::bus_rsp_t bus_rsp,
  output gen_pkg::sample_t  dac,
  output logic              dac_valid,
  input  logic              dac_ready,
  output logic              irq
);

  gen_pkg::gen_cfg_t cfg;
  gen_pkg::gen_ctl_t ctl;
  gen_pkg::gen_sts_t sts;
  logic              tbl_we;
  // producer to buffer
  logic              push;
  gen_pkg::gen_smp_t push_smp;
  logic              credit_ret;
  // buffer to output stage
  logic              pop;
  gen_pkg::gen_smp_t head_smp;
  logic              not_empty;

  gen_regs i_regs (
    .bus     (bus),
    .ctl_rst (ctl_rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .cfg     (cfg),
    .ctl     (ctl),
    .sts     (sts),
    .tbl_we  (tbl_we),
    .irq     (irq)
  );

  gen_table_reader #(
    .AW    (AW),
    .DEPTH (DEPTH)
  ) i_reader (
    .bus        (bus),
    .ctl_rst    (ctl_rst),
    .cfg        (cfg),
    .ctl        (ctl),
    .tbl_we     (tbl_we),
    .bus_req    (bus_req),
    .sts        (sts),
    .push       (push),
    .smp        (push_smp),
    .credit_ret (credit_ret)
  );

  gen_credit_fifo #(
    .DEPTH (DEPTH)
  ) i_fifo (
    .bus        (bus),
    .ctl_rst    (ctl_rst),
    .push       (push),
    .smp_in     (push_smp),
    .pop        (pop),
    .smp_out    (head_smp),
    .not_empty  (not_empty),
    .credit_ret (credit_ret)
  );

  gen_lin_out i_lin (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .cfg       (cfg),
    .not_empty (not_empty),
    .smp       (head_smp),
    .pop       (pop),
    .dac       (dac),
    .dac_valid (dac_valid),
    .dac_ready (dac_ready)
  );

endmodule

`default_nettype wire
